/* testbench/pixel_trace.txt */
// repeat count (decimal), overlay pixel rrggbb (hex)
// first frame runs with no overlay, the rest mixes overlay patterns
180 000000
24 ffffff
24 0f0f0f
24 808080
12 ff0f80
12 800fff
8 000000
6 f0f0f0
6 555555
6 aaaaaa
10 0f8000
10 00ff0f
9 123456
9 fedcba
7 010101
7 7f7f7f
16 c3c3c3
16 3c3c3c
5 ff0000
5 00ff00
5 0000ff
20 e0e0e0
20 1f1f1f
30 0f0f0f
40 ffffff
30 808080
20 000000

/* src.f */
+incdir+include
rtl/dvi_pkg.sv
rtl/video_timing.sv
rtl/color_bars.sv
rtl/tmds_encoder.sv
rtl/dvi_transmitter.sv
testbench/dvi_tb.sv

/* Makefile */
# Verilator build for the DVI transmitter testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := dvi_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# a failing check ends in $$fatal, which gives a nonzero exit status
run: compile
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

/* include/tmds_ref.svh */
`ifndef TMDS_REF_SVH
`define TMDS_REF_SVH

// transmitter model stepped once per pixel clock by ref_step
// uses H_ACTIVE .. V_TOTAL and BAR_WIDTH from the including scope

int                  ref_h;
int                  ref_v;
int                  ref_pix;
logic [3:0]          ref_bar;
dvi_pkg::sync_t      ref_sync;
dvi_pkg::disparity_t ref_bias [3]; // red, green, blue
dvi_pkg::tmds_bus_t  ref_tmds;     // expected output after the edge

function automatic dvi_pkg::tmds_word_t ref_encode(input logic [7:0] data,
		input logic blank, input dvi_pkg::ctrl_t ctrl, inout dvi_pkg::disparity_t bias);
	logic [8:0]          q;
	logic                use_xnor;
	int                  n1;
	int                  n0;
	int                  cnt; // full dvi units, twice the stored bias
	dvi_pkg::tmds_word_t word;
	use_xnor = ($countones(data) > 4) || ($countones(data) == 4 && !data[0]);
	q[0] = data[0];
	for (int i = 1; i < 8; i++) begin
		q[i] = use_xnor ? ~(data[i] ^ q[i-1]) : data[i] ^ q[i-1];
	end
	q[8] = !use_xnor;
	n1 = $countones(q[7:0]);
	n0 = 8 - n1;
	cnt = 2 * $signed(bias);
	if (blank) begin
		word = dvi_pkg::CTRL_SYMBOL[ctrl];
		cnt = 0;
	end else if (cnt == 0 || n1 == n0) begin
		word = {~q[8], q[8], q[8] ? q[7:0] : ~q[7:0]};
		cnt = q[8] ? cnt + n1 - n0 : cnt + n0 - n1;
	end else if ((cnt > 0 && n1 > n0) || (cnt < 0 && n0 > n1)) begin
		word = {1'b1, q[8], ~q[7:0]};
		cnt = cnt + 2 * int'(q[8]) + n0 - n1;
	end else begin
		word = {1'b0, q[8], q[7:0]};
		cnt = cnt - 2 * int'(!q[8]) + n1 - n0;
	end
	bias = dvi_pkg::disparity_t'(cnt / 2);
	return word;
endfunction

task automatic ref_reset();
	ref_h    = 0;
	ref_v    = 0;
	ref_pix  = 0;
	ref_bar  = '0;
	ref_sync = '0;
	ref_bias = '{default: '0};
	ref_tmds.red   = dvi_pkg::CTRL_SYMBOL[0];
	ref_tmds.green = dvi_pkg::CTRL_SYMBOL[0];
	ref_tmds.blue  = dvi_pkg::CTRL_SYMBOL[0];
endtask

// advance one clock with the overlay seen before the edge
task automatic ref_step(input dvi_pkg::pixel_t overlay);
	dvi_pkg::pixel_t pix;
	pix = overlay | ((ref_bar <= 4'd12) ? dvi_pkg::BAR_COLORS[ref_bar]
		: dvi_pkg::BAR_COLORS[13]);
	ref_tmds.red   = ref_encode(pix.red, ref_sync.blank, 2'b00, ref_bias[0]);
	ref_tmds.green = ref_encode(pix.green, ref_sync.blank, 2'b00, ref_bias[1]);
	ref_tmds.blue  = ref_encode(pix.blue, ref_sync.blank,
		{~ref_sync.vsync, ~ref_sync.hsync}, ref_bias[2]);
	if (ref_sync.blank || ref_pix == BAR_WIDTH - 1) begin
		ref_bar = ref_sync.blank ? 4'd0 : ref_bar + 4'd1;
		ref_pix = 0;
	end else begin
		ref_pix++;
	end
	ref_sync.blank = (ref_h >= H_ACTIVE) || (ref_v >= V_ACTIVE);
	ref_sync.hsync = (ref_h >= H_SYNC_START) && (ref_h < H_SYNC_END);
	ref_sync.vsync = (ref_v >= V_SYNC_START) && (ref_v < V_SYNC_END);
	if (ref_h == H_TOTAL - 1) begin
		ref_h = 0;
		ref_v = (ref_v == V_TOTAL - 1) ? 0 : ref_v + 1;
	end else begin
		ref_h++;
	end
endtask

`endif

/* testbench/dvi_tb.sv */
`timescale 1ns/10ps

module dvi_tb;

	// small raster so a frame is 24 x 7 = 168 cycles
	localparam int H_ACTIVE     = 16;
	localparam int H_SYNC_START = 18;
	localparam int H_SYNC_END   = 21;
	localparam int H_TOTAL      = 24;
	localparam int V_ACTIVE     = 4;
	localparam int V_SYNC_START = 5;
	localparam int V_SYNC_END   = 6;
	localparam int V_TOTAL      = 7;
	localparam int BAR_WIDTH    = 3;

	localparam int    FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int    CLK_PERIOD   = 100; // ns
	localparam string TRACE_FILE   = "testbench/pixel_trace.txt";

	logic               clk;
	logic               reset;
	dvi_pkg::pixel_t    overlay;
	dvi_pkg::tmds_bus_t tmds;

	int              trace_count [$]; // repeat count per trace line
	dvi_pkg::pixel_t trace_pixel [$];
	longint          total_cycles = 0;
	longint          watchdog_ns  = 0;

	`include "tmds_ref.svh"

	dvi_transmitter #(
		.H_ACTIVE(H_ACTIVE), .H_SYNC_START(H_SYNC_START),
		.H_SYNC_END(H_SYNC_END), .H_TOTAL(H_TOTAL),
		.V_ACTIVE(V_ACTIVE), .V_SYNC_START(V_SYNC_START),
		.V_SYNC_END(V_SYNC_END), .V_TOTAL(V_TOTAL),
		.BAR_WIDTH(BAR_WIDTH)
	) dvi_transmitter_inst (
		.clk(clk), .reset(reset), .overlay(overlay), .tmds(tmds)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string reason);
		$display("*** FAILED ***");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_tmds(input string name, input dvi_pkg::tmds_word_t expected,
			input dvi_pkg::tmds_word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED time=%0t %s expected=%b actual=%b",
				$time, name, expected, actual);
			abort_run("tmds output differs from the reference model");
		end
	endtask

	// outputs settled since the rising edge while inputs are unchanged
	task automatic check_cycle();
		if (reset) begin
			ref_reset();
		end else begin
			ref_step(overlay);
		end
		check_tmds("tmds.red", ref_tmds.red, tmds.red);
		check_tmds("tmds.green", ref_tmds.green, tmds.green);
		check_tmds("tmds.blue", ref_tmds.blue, tmds.blue);
	endtask

	task automatic load_trace();
		int          fd;
		int          count;
		logic [23:0] pix;
		string       line;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			abort_run({"cannot open trace file ", TRACE_FILE});
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.substr(0, 1) == "//") begin
					// comment or empty line
				end else if ($sscanf(line, "%d %h", count, pix) != 2 || count <= 0) begin
					abort_run({"malformed line in trace file: ", line});
				end else begin
					trace_count.push_back(count);
					trace_pixel.push_back(pix);
					total_cycles += count;
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		clk     = 1'b0;
		reset   = 1'b1;
		overlay = '0;
		load_trace();
		if (total_cycles < 2 * FRAME_CYCLES) begin
			abort_run("trace file is shorter than two video frames");
		end else begin
			watchdog_ns = total_cycles * CLK_PERIOD + 10 * CLK_PERIOD;
			repeat (2) begin
				@(negedge clk);
				check_cycle();
			end
			reset = 1'b0;
			foreach (trace_count[i]) begin
				repeat (trace_count[i]) begin
					overlay = trace_pixel[i];
					@(negedge clk);
					check_cycle();
				end
			end
			$display("*** PASSED ***");
			$finish;
		end
	end

	// limit follows the trace length
	initial begin
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		abort_run("watchdog expired before the end of the trace");
	end

endmodule

/* rtl/dvi_transmitter.sv */
`timescale 1ns/10ps

module dvi_transmitter #(
	parameter int H_ACTIVE     = dvi_pkg::DEF_H_ACTIVE,
	parameter int H_SYNC_START = dvi_pkg::DEF_H_SYNC_START,
	parameter int H_SYNC_END   = dvi_pkg::DEF_H_SYNC_END,
	parameter int H_TOTAL      = dvi_pkg::DEF_H_TOTAL,
	parameter int V_ACTIVE     = dvi_pkg::DEF_V_ACTIVE,
	parameter int V_SYNC_START = dvi_pkg::DEF_V_SYNC_START,
	parameter int V_SYNC_END   = dvi_pkg::DEF_V_SYNC_END,
	parameter int V_TOTAL      = dvi_pkg::DEF_V_TOTAL,
	parameter int BAR_WIDTH    = dvi_pkg::DEF_BAR_WIDTH
) (
	input  logic               clk,
	input  logic               reset,
	input  dvi_pkg::pixel_t    overlay,
	output dvi_pkg::tmds_bus_t tmds
);

	dvi_pkg::sync_t  sync;
	dvi_pkg::pixel_t bar_color;
	dvi_pkg::pixel_t pixel;     // bars with overlay on top
	dvi_pkg::ctrl_t  sync_ctrl; // only blue carries it

	video_timing #(
		.H_ACTIVE(H_ACTIVE), .H_SYNC_START(H_SYNC_START),
		.H_SYNC_END(H_SYNC_END), .H_TOTAL(H_TOTAL),
		.V_ACTIVE(V_ACTIVE), .V_SYNC_START(V_SYNC_START),
		.V_SYNC_END(V_SYNC_END), .V_TOTAL(V_TOTAL)
	) video_timing_inst (.clk(clk), .reset(reset), .sync(sync));

	color_bars #(.BAR_WIDTH(BAR_WIDTH)) color_bars_inst (
		.clk(clk), .reset(reset), .sync(sync), .bar_color(bar_color)
	);

	assign pixel.red   = bar_color.red   | overlay.red;
	assign pixel.green = bar_color.green | overlay.green;
	assign pixel.blue  = bar_color.blue  | overlay.blue;

	assign sync_ctrl = {~sync.vsync, ~sync.hsync}; // syncs are sent inverted

	tmds_encoder #(.CTRL_EN(1'b0)) enc_red (
		.clk(clk), .reset(reset), .data(pixel.red), .blank(sync.blank),
		.ctrl(sync_ctrl), .tmds(tmds.red)
	);

	tmds_encoder #(.CTRL_EN(1'b0)) enc_green (
		.clk(clk), .reset(reset), .data(pixel.green), .blank(sync.blank),
		.ctrl(sync_ctrl), .tmds(tmds.green)
	);

	tmds_encoder #(.CTRL_EN(1'b1)) enc_blue (
		.clk(clk), .reset(reset), .data(pixel.blue), .blank(sync.blank),
		.ctrl(sync_ctrl), .tmds(tmds.blue)
	);

endmodule

/* rtl/tmds_encoder.sv */
`timescale 1ns/10ps

module tmds_encoder #(
	parameter bit CTRL_EN = 1'b1 // 0 sends control pair 00 whatever ctrl holds
) (
	input  logic                clk,
	input  logic                reset,
	input  logic [7:0]          data,
	input  logic                blank,
	input  dvi_pkg::ctrl_t      ctrl,
	output dvi_pkg::tmds_word_t tmds
);

	logic [8:0]          xored;
	logic [8:0]          xnored;
	logic [8:0]          q_m;       // transition minimised word
	logic [3:0]          ones;
	dvi_pkg::disparity_t word_disp; // ones minus four of q_m[7:0]
	dvi_pkg::disparity_t bias;      // running dc bias
	dvi_pkg::ctrl_t      ctrl_sel;

	assign ctrl_sel = CTRL_EN ? ctrl : 2'b00;

	always_comb begin
		xored[0]  = data[0];
		xnored[0] = data[0];
		for (int i = 1; i < 8; i++) begin
			xored[i]  = data[i] ^ xored[i-1];
			xnored[i] = data[i] ~^ xnored[i-1];
		end
		xored[8]  = 1'b1;
		xnored[8] = 1'b0; // flags the xnor form
	end

	always_comb begin
		ones = 4'd0;
		for (int i = 0; i < 8; i++) begin
			ones = ones + 4'(data[i]);
		end
	end

	assign q_m = ((ones > 4'd4) || (ones == 4'd4 && !data[0])) ? xnored : xored;

	always_comb begin
		word_disp = 4'b1100; // start at -4
		for (int i = 0; i < 8; i++) begin
			word_disp = word_disp + 4'(q_m[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tmds <= dvi_pkg::CTRL_SYMBOL[0];
			bias <= '0;
		end else if (blank) begin
			tmds <= dvi_pkg::CTRL_SYMBOL[ctrl_sel];
			bias <= '0; // each active run starts balanced
		end else if (bias == 4'd0 || word_disp == 4'd0) begin
			// no bias to correct so bit 9 follows bit 8
			tmds <= q_m[8] ? {2'b01, q_m[7:0]} : {2'b10, ~q_m[7:0]};
			bias <= q_m[8] ? bias + word_disp : bias - word_disp;
		end else if (bias[3] == word_disp[3]) begin
			tmds <= {1'b1, q_m[8], ~q_m[7:0]}; // same sign so invert to pull back
			bias <= bias + {3'b000, q_m[8]} - word_disp;
		end else begin
			tmds <= {1'b0, q_m[8], q_m[7:0]};
			bias <= bias - {3'b000, ~q_m[8]} + word_disp;
		end
	end

endmodule

/* rtl/color_bars.sv */
`timescale 1ns/10ps

module color_bars #(
	parameter int BAR_WIDTH = dvi_pkg::DEF_BAR_WIDTH
) (
	input  logic            clk,
	input  logic            reset,
	input  dvi_pkg::sync_t  sync,
	output dvi_pkg::pixel_t bar_color
);

	localparam int PIX_W = (BAR_WIDTH > 1) ? $clog2(BAR_WIDTH) : 1;

	logic [PIX_W-1:0] pix_cnt; // pixel within current bar
	logic [3:0]       bar_idx;
	logic             bar_end;
	logic [3:0]       color_sel;

	assign bar_end = (pix_cnt == PIX_W'(BAR_WIDTH - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt <= '0;
			bar_idx <= '0;
		end else if (sync.blank) begin
			// restart at the left edge of every line
			pix_cnt <= '0;
			bar_idx <= '0;
		end else if (bar_end) begin
			pix_cnt <= '0;
			bar_idx <= bar_idx + 1'b1;
		end else begin
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

	// anything past the table shows black
	assign color_sel = (bar_idx > 4'd13) ? 4'd13 : bar_idx;
	assign bar_color = dvi_pkg::BAR_COLORS[color_sel];

endmodule

/* rtl/video_timing.sv */
`timescale 1ns/10ps

module video_timing #(
	parameter int H_ACTIVE     = dvi_pkg::DEF_H_ACTIVE,
	parameter int H_SYNC_START = dvi_pkg::DEF_H_SYNC_START,
	parameter int H_SYNC_END   = dvi_pkg::DEF_H_SYNC_END,
	parameter int H_TOTAL      = dvi_pkg::DEF_H_TOTAL,
	parameter int V_ACTIVE     = dvi_pkg::DEF_V_ACTIVE,
	parameter int V_SYNC_START = dvi_pkg::DEF_V_SYNC_START,
	parameter int V_SYNC_END   = dvi_pkg::DEF_V_SYNC_END,
	parameter int V_TOTAL      = dvi_pkg::DEF_V_TOTAL
) (
	input  logic            clk,
	input  logic            reset,
	output dvi_pkg::sync_t  sync
);

	localparam int W = dvi_pkg::CNT_W;

	logic [W-1:0] h_cnt; // pixel within line
	logic [W-1:0] v_cnt; // line within frame
	logic         h_last;
	logic         v_last;

	assign h_last = (h_cnt == W'(H_TOTAL - 1));
	assign v_last = (v_cnt == W'(V_TOTAL - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
			sync  <= '0;
		end else begin
			// free running raster
			if (h_last) begin
				h_cnt <= '0;
				if (v_last) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end

			// registered so one cycle behind the counters
			sync.blank <= (h_cnt >= W'(H_ACTIVE)) || (v_cnt >= W'(V_ACTIVE));
			sync.hsync <= (h_cnt >= W'(H_SYNC_START)) && (h_cnt < W'(H_SYNC_END));
			sync.vsync <= (v_cnt >= W'(V_SYNC_START)) && (v_cnt < W'(V_SYNC_END));
		end
	end

endmodule

/* rtl/dvi_pkg.sv */
package dvi_pkg;

	localparam int CNT_W = 10; // timing counter width

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

	typedef struct packed {
		logic blank;
		logic hsync;
		logic vsync;
	} sync_t;

	typedef logic [9:0] tmds_word_t;

	typedef struct packed {
		tmds_word_t red;
		tmds_word_t green;
		tmds_word_t blue;
	} tmds_bus_t;

	typedef logic [1:0] ctrl_t;      // {c1, c0}
	typedef logic [3:0] disparity_t; // two's complement

	// 640x480 at 60 Hz
	localparam int DEF_H_ACTIVE     = 640;
	localparam int DEF_H_SYNC_START = 656;
	localparam int DEF_H_SYNC_END   = 752;
	localparam int DEF_H_TOTAL      = 800;
	localparam int DEF_V_ACTIVE     = 480;
	localparam int DEF_V_SYNC_START = 490;
	localparam int DEF_V_SYNC_END   = 492;
	localparam int DEF_V_TOTAL      = 525;
	localparam int DEF_BAR_WIDTH    = 50;

	localparam tmds_word_t CTRL_SYMBOL [4] = '{
		10'b1101010100, 10'b0010101011, 10'b0101010100, 10'b1010101011
	};

	localparam pixel_t BAR_COLORS [14] = '{
		24'hc0c0c0, 24'hc0c000, 24'h00c000, 24'h00c0c0, 24'hc000c0, 24'hc00000, 24'h0000c0,
		24'h131313, 24'h00214c, 24'hffffff, 24'h32006a, 24'h090909, 24'h1d1d1d, 24'h000000
	};

endpackage
